// ==== source/vdp_macros.svh ====
// ----------------------------------------------------------
// vdp compositor shared constants
// pipeline depth of the blender, output buffer size and the
// credits held toward the downstream consumer after reset
// ----------------------------------------------------------

`ifndef VDP_MACROS_SVH
`define VDP_MACROS_SVH

// cycles from an accepted input pixel to the blended pixel
// written into the output buffer
`define VDP_BLEND_LATENCY 4

// output buffer entries, also the upstream credits after reset
`define VDP_OUT_DEPTH 8

// credits toward the downstream consumer after reset
`define VDP_DOWN_CREDITS 4

`endif

// ==== source/vdp_pkg.sv ====
// ----------------------------------------------------------
// vdp compositor types
// colour formats, the layered input pixel and the pair of
// alpha scale factors read from the alpha table
// ----------------------------------------------------------

`default_nettype none

package vdp_pkg;

    // 16 bit colour with alpha, alpha in the top nibble
    typedef struct packed {
        logic [3:0] alpha;
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } argb4444_t;

    // 12 bit output colour
    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb444_t;

    // one pixel position from both layers
    // source is the upper layer, dest the lower one
    typedef struct packed {
        logic      source_enable;
        argb4444_t source;
        argb4444_t dest;
    } layer_pixel_t;

    // multipliers in 1/16 steps, 16 means full weight
    typedef struct packed {
        logic [4:0] source_scale;
        logic [4:0] dest_scale;
    } alpha_scale_t;

endpackage

`default_nettype wire

// ==== source/vdp_delay_line.sv ====
// ----------------------------------------------------------
// vdp delay line
// fixed length register chain for an arbitrary payload type,
// cleared on reset, zero length passes the data through
// ----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module vdp_delay_line #(
    parameter type payload_t = logic,
    parameter int  delay     = 1
) (
    input  wire logic     clk,
    input  wire logic     arst_n,
    input  wire payload_t in_data,
    output payload_t      out_data
);

    generate
        if (delay == 0) begin : g_pass
            assign out_data = in_data;
        end else begin : g_chain
            payload_t stage_q [delay];

            always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                    for (int i = 0; i < delay; i++) begin
                        stage_q[i] <= '0;
                    end
                end else begin
                    stage_q[0] <= in_data;
                    // shift toward the output end
                    for (int i = 1; i < delay; i++) begin
                        stage_q[i] <= stage_q[i - 1];
                    end
                end
            end

            assign out_data = stage_q[delay - 1];
        end
    endgenerate

endmodule

`default_nettype wire

// ==== source/vdp_alpha_lut.sv ====
// ----------------------------------------------------------
// vdp alpha table
// 256 entry rom of source and destination scale factors,
// indexed by destination and source alpha, registered read
// ----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module vdp_alpha_lut (
    input  wire logic         clk,
    input  wire logic [3:0]   source_alpha,
    input  wire logic [3:0]   dest_alpha,
    output vdp_pkg::alpha_scale_t scale
);

    import vdp_pkg::*;

    // address is {dest alpha, source alpha}
    alpha_scale_t lut_mem [256];

    // scale pair for one alpha combination
    function automatic alpha_scale_t blend_scales(
        input logic [3:0] dest_a,
        input logic [3:0] src_a
    );
        int           src_base;
        int           dst_base;
        alpha_scale_t result;
        // alpha 0 is fully transparent, otherwise alpha + 1
        src_base = (src_a == 4'h0) ? 0 : int'(src_a) + 1;
        dst_base = (dest_a == 4'h0) ? 0 : int'(dest_a) + 1;
        result.source_scale = 5'(src_base);
        // dest only gets what the source leaves over
        result.dest_scale = 5'(((16 - src_base) * dst_base) / 16);
        return result;
    endfunction

    // table contents fixed at elaboration
    initial begin
        for (int addr = 0; addr < 256; addr++) begin
            lut_mem[addr] = blend_scales(4'(addr / 16), 4'(addr % 16));
        end
    end

    // registered read so the table lands in block ram
    always_ff @(posedge clk) begin
        scale <= lut_mem[{dest_alpha, source_alpha}];
    end

endmodule

`default_nettype wire

// ==== source/vdp_blender.sv ====
// ----------------------------------------------------------
// vdp blender
// four stage alpha blend of an upper and a lower layer pixel
// into one rgb444 pixel, one result per cycle, never stalls
// ----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "vdp_macros.svh"

module vdp_blender (
    input  wire logic                  clk,
    input  wire logic                  arst_n,
    input  wire logic                  in_valid,
    input  wire vdp_pkg::layer_pixel_t in_pixel,
    output logic                       blend_valid,
    output vdp_pkg::rgb444_t           blend_pixel
);

    import vdp_pkg::*;

    typedef struct packed {
        rgb444_t source;
        rgb444_t dest;
    } colour_pair_t;

    // stage 1 registers
    logic [3:0]       lut_source_alpha;
    logic [3:0]       lut_dest_alpha;
    colour_pair_t     pair_s1;

    // stage 2, aligned with the table output
    colour_pair_t     pair_s2;
    alpha_scale_t     scale_s2;
    logic [2:0][3:0]  src_chan;
    logic [2:0][3:0]  dst_chan;

    // stage 3 products, index 2 is red
    logic [2:0][8:0]  src_prod;
    logic [2:0][8:0]  dst_prod;

    // stage 4 rounding
    logic [2:0][5:0]  chan_sum;
    logic [2:0][3:0]  blend_chan;

    function automatic rgb444_t to_rgb(input argb4444_t c);
        rgb444_t result;
        result.red   = c.red;
        result.green = c.green;
        result.blue  = c.blue;
        return result;
    endfunction

    // valid runs alongside the whole pipeline
    vdp_delay_line #(
        .payload_t (logic),
        .delay     (`VDP_BLEND_LATENCY)
    ) i_valid_delay (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_data  (in_valid),
        .out_data (blend_valid)
    );

    // stage 1: table address, hidden source counts as transparent
    always_ff @(posedge clk) begin
        lut_source_alpha <= in_pixel.source_enable ? in_pixel.source.alpha : 4'h0;
        lut_dest_alpha   <= in_pixel.dest.alpha;
        pair_s1.source   <= to_rgb(in_pixel.source);
        pair_s1.dest     <= to_rgb(in_pixel.dest);
    end

    // stage 2: table read
    vdp_alpha_lut i_alpha_lut (
        .clk          (clk),
        .source_alpha (lut_source_alpha),
        .dest_alpha   (lut_dest_alpha),
        .scale        (scale_s2)
    );

    // colours wait one cycle for the table
    vdp_delay_line #(
        .payload_t (colour_pair_t),
        .delay     (1)
    ) i_colour_delay (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_data  (pair_s1),
        .out_data (pair_s2)
    );

    assign src_chan = pair_s2.source;
    assign dst_chan = pair_s2.dest;

    // stage 3: six 4x5 multiplies
    always_ff @(posedge clk) begin
        for (int c = 0; c < 3; c++) begin
            src_prod[c] <= src_chan[c] * scale_s2.source_scale;
            dst_prod[c] <= dst_chan[c] * scale_s2.dest_scale;
        end
    end

    // keep one fraction bit of each product, round, drop the fraction
    always_comb begin
        for (int c = 0; c < 3; c++) begin
            chan_sum[c]   = {1'b0, 5'(src_prod[c] >> 3)} + {1'b0, 5'(dst_prod[c] >> 3)} + 6'd1;
            blend_chan[c] = 4'(chan_sum[c] >> 1);
        end
    end

    // stage 4
    always_ff @(posedge clk) begin
        blend_pixel <= blend_chan;
    end

endmodule

`default_nettype wire

// ==== source/vdp_credit_fifo.sv ====
// ----------------------------------------------------------
// vdp output buffer
// circular buffer of blended pixels that sends on downstream
// credits and returns one upstream credit per sent pixel
// ----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "vdp_macros.svh"

module vdp_credit_fifo #(
    parameter int depth        = `VDP_OUT_DEPTH,
    parameter int down_credits = `VDP_DOWN_CREDITS
) (
    input  wire logic             clk,
    input  wire logic             arst_n,
    input  wire logic             wr_valid,
    input  wire vdp_pkg::rgb444_t wr_pixel,
    output logic                  out_valid,
    output vdp_pkg::rgb444_t      out_pixel,
    input  wire logic             out_credit,
    output logic                  in_credit
);

    import vdp_pkg::*;

    localparam int ptr_w  = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w  = $clog2(depth + 1);
    localparam int cred_w = $clog2(down_credits + 1);

    rgb444_t             buf_mem [depth];
    logic [ptr_w-1:0]    wr_ptr;
    logic [ptr_w-1:0]    rd_ptr;
    logic [cnt_w-1:0]    count;
    logic [cred_w-1:0]   credit_cnt;
    logic                send_next;
    logic                bypass;
    logic                store;
    logic                pop;

    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
        return (p == ptr_w'(depth - 1)) ? '0 : p + 1'b1;
    endfunction

    // next send needs a pixel and a credit already held
    always_comb begin
        send_next = ((count != '0) || wr_valid) && (credit_cnt != '0);
        // new pixel goes straight to the output when the buffer is empty
        bypass    = send_next && (count == '0);
        store     = wr_valid && !bypass;
        pop       = send_next && (count != '0);
    end

    always_ff @(posedge clk) begin
        if (store) begin
            buf_mem[wr_ptr] <= wr_pixel;
        end
        if (send_next) begin
            out_pixel <= bypass ? wr_pixel : buf_mem[rd_ptr];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            credit_cnt <= cred_w'(down_credits);
            out_valid  <= 1'b0;
            in_credit  <= 1'b0;
        end else begin
            if (store) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count      <= count + cnt_w'(store) - cnt_w'(pop);
            credit_cnt <= credit_cnt + cred_w'(out_credit) - cred_w'(send_next);
            // a sent pixel frees its entry in the same cycle
            out_valid  <= send_next;
            in_credit  <= send_next;
        end
    end

endmodule

`default_nettype wire

// ==== source/vdp_compositor.sv ====
// ----------------------------------------------------------
// vdp layer compositor
// alpha blends two layers per pixel and hands the result to
// a credit controlled output buffer
// ----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "vdp_macros.svh"

module vdp_compositor (
    input  wire logic                  clk,
    input  wire logic                  arst_n,

    // upstream, producer holds credits
    input  wire logic                  in_valid,
    input  wire vdp_pkg::layer_pixel_t in_pixel,
    output logic                       in_credit,

    // downstream, consumer returns credits
    output logic                       out_valid,
    output vdp_pkg::rgb444_t           out_pixel,
    input  wire logic                  out_credit
);

    import vdp_pkg::*;

    logic    blend_valid;
    rgb444_t blend_pixel;

    vdp_blender i_blender (
        .clk         (clk),
        .arst_n      (arst_n),
        .in_valid    (in_valid),
        .in_pixel    (in_pixel),
        .blend_valid (blend_valid),
        .blend_pixel (blend_pixel)
    );

    // buffer size matches the upstream credits after reset
    vdp_credit_fifo #(
        .depth (`VDP_OUT_DEPTH)
    ) i_out_fifo (
        .clk        (clk),
        .arst_n     (arst_n),
        .wr_valid   (blend_valid),
        .wr_pixel   (blend_pixel),
        .out_valid  (out_valid),
        .out_pixel  (out_pixel),
        .out_credit (out_credit),
        .in_credit  (in_credit)
    );

endmodule

`default_nettype wire

// ==== test/vdp_blend_model.svh ====
// ----------------------------------------------------------
// vdp compositor reference model
// blend rule of the layer compositor and the lfsr that feeds
// the random stimulus
// ----------------------------------------------------------

`ifndef VDP_BLEND_MODEL_SVH
`define VDP_BLEND_MODEL_SVH

// fibonacci lfsr, x^16 + x^14 + x^13 + x^11 + 1, one shift per call
function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    logic feedback;
    feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
    return {state[14:0], feedback};
endfunction

// products keep one fraction bit, the sum is rounded away
function automatic logic [3:0] blend_channel(input int src_c, input int dst_c,
                                             input int src_scale, input int dst_scale);
    int src_part;
    int dst_part;
    src_part = (src_c * src_scale) >> 3;
    dst_part = (dst_c * dst_scale) >> 3;
    return 4'(((src_part + dst_part + 1) >> 1) & 15);
endfunction

function automatic vdp_pkg::rgb444_t blend_reference(input vdp_pkg::layer_pixel_t p);
    int               src_scale;
    int               dst_base;
    int               dst_scale;
    vdp_pkg::rgb444_t result;
    // hidden or transparent source weighs nothing
    src_scale = (!p.source_enable || p.source.alpha == 0) ? 0 : int'(p.source.alpha) + 1;
    dst_base  = (p.dest.alpha == 0) ? 0 : int'(p.dest.alpha) + 1;
    dst_scale = ((16 - src_scale) * dst_base) / 16;
    result.red   = blend_channel(p.source.red, p.dest.red, src_scale, dst_scale);
    result.green = blend_channel(p.source.green, p.dest.green, src_scale, dst_scale);
    result.blue  = blend_channel(p.source.blue, p.dest.blue, src_scale, dst_scale);
    return result;
endfunction

`endif

// ==== test/vdp_compositor_tb.sv ====
// ----------------------------------------------------------
// vdp compositor testbench
// credit respecting random layer pixels, scoreboard against
// the reference blend, credit accounting on both sides
// ----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "vdp_macros.svh"

module vdp_compositor_tb;

    import vdp_pkg::*;

    `include "vdp_blend_model.svh"

    localparam int     clk_period_ns = 100;
    localparam int     reset_cycles  = 10;
    localparam int     num_pixels    = 2000;
    localparam int     stall_max     = 64;
    // a full consumer stall plus the credit round trip
    localparam int     worst_gap     = stall_max + 8;
    localparam longint timeout_ns    =
        2 * longint'(num_pixels + reset_cycles) * worst_gap * clk_period_ns;
    // one edge to take the input, the blend, one edge in the buffer
    localparam int     min_latency   = `VDP_BLEND_LATENCY + 2;

    logic         clk = 1'b0;
    logic         arst_n;
    logic         in_valid;
    layer_pixel_t in_pixel;
    logic         in_credit;
    logic         out_valid;
    rgb444_t      out_pixel;
    logic         out_credit;

    logic [15:0]  lfsr_state;
    rgb444_t      exp_queue [$];
    int           sent_queue [$];
    int           cycle;
    int           sent_up;
    int           received;
    int           up_credits;
    int           sent_down;
    int           returned;
    int           owed;
    int           stall_left;
    int           pixel_errors;
    int           count_errors;

    vdp_compositor i_dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .in_pixel   (in_pixel),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_pixel  (out_pixel),
        .out_credit (out_credit)
    );

    always #(clk_period_ns / 2) clk = ~clk;

    function automatic int random_bits(input int n);
        int value;
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
        return value;
    endfunction

    task automatic check_pixel(input rgb444_t got, input rgb444_t expected, input int index);
        if (got !== expected) begin
            pixel_errors++;
            $display("Error at %0t: pixel %0d is %03h, expected %03h",
                     $time, index, got, expected);
        end
    endtask

    task automatic check_count(input string what, input int got, input int expected);
        if (got != expected) begin
            count_errors++;
            $display("Error at %0t: %s is %0d, expected %0d", $time, what, got, expected);
        end
    endtask

    // random colours, some alpha corner cases forced
    task automatic next_pixel(output layer_pixel_t p, output rgb444_t expected);
        int mode;
        mode            = random_bits(3);
        p.source        = 16'(random_bits(16));
        p.dest          = 16'(random_bits(16));
        p.source_enable = 1'b1;
        case (mode)
            0: p.source.alpha = 4'hf;
            4: begin
                if (random_bits(1) == 1) begin
                    p.source_enable = 1'b0;
                end else begin
                    p.source.alpha = 4'h0;
                end
            end
            5: begin
                p.source_enable = 1'b0;
                p.dest.alpha    = 4'hf;
            end
            6: begin
                p.source.alpha = 4'hf;
                p.dest.alpha   = 4'h0;
            end
            7: begin
                p.source.alpha = 4'h0;
                p.dest.alpha   = 4'h0;
            end
            default: ;
        endcase
        // full weight on one side gives that colour back, none gives black
        case (mode)
            5: expected = {p.dest.red, p.dest.green, p.dest.blue};
            6: expected = {p.source.red, p.source.green, p.source.blue};
            7: expected = '0;
            default: expected = blend_reference(p);
        endcase
    endtask

    // sample outputs of the last cycle, then drive the next one
    task automatic run_cycle();
        layer_pixel_t p;
        rgb444_t      expected;
        rgb444_t      head;
        int           sent_at;
        @(posedge clk);
        cycle++;
        check_count("in_credit against out_valid", int'(in_credit), int'(out_valid));
        if (in_credit) begin
            up_credits++;
        end
        check_count("upstream credits out of range",
                    (up_credits < 0 || up_credits > `VDP_OUT_DEPTH) ? 1 : 0, 0);
        if (out_valid) begin
            sent_down++;
            owed++;
            check_count("sends beyond downstream credits",
                        (sent_down > `VDP_DOWN_CREDITS + returned) ? 1 : 0, 0);
            if (exp_queue.size() == 0) begin
                check_count("extra output pixels", 1, 0);
            end else begin
                head    = exp_queue.pop_front();
                sent_at = sent_queue.pop_front();
                check_pixel(out_pixel, head, received);
                check_count("pixel ahead of pipeline latency",
                            (cycle - sent_at < min_latency) ? 1 : 0, 0);
                received++;
            end
        end
        if (out_credit) begin
            returned++;
        end

        if (sent_up < num_pixels && up_credits > 0 && random_bits(2) != 0) begin
            next_pixel(p, expected);
            exp_queue.push_back(expected);
            sent_queue.push_back(cycle);
            up_credits--;
            sent_up++;
            in_valid <= 1'b1;
            in_pixel <= p;
        end else begin
            in_valid <= 1'b0;
        end

        // consumer holds back credits in long random stretches
        if (stall_left > 0) begin
            stall_left--;
        end else if (random_bits(6) == 0) begin
            stall_left = random_bits(6) + 1;
        end
        if (owed > 0 && stall_left == 0 && random_bits(1) == 1) begin
            owed--;
            out_credit <= 1'b1;
        end else begin
            out_credit <= 1'b0;
        end
    endtask

    initial begin
        arst_n     = 1'b0;
        in_valid   = 1'b0;
        in_pixel   = '0;
        out_credit = 1'b0;
        lfsr_state = 16'd93;
        up_credits = `VDP_OUT_DEPTH;
        repeat (reset_cycles) @(posedge clk);
        arst_n <= 1'b1;

        // idle after reset
        repeat (20) begin
            @(posedge clk);
            check_count("out_valid while idle", int'(out_valid), 0);
            check_count("in_credit while idle", int'(in_credit), 0);
        end

        while (received < num_pixels || owed > 0) begin
            run_cycle();
        end
        // quiet tail, nothing more may come out
        repeat (20) run_cycle();

        check_count("pixels delivered", received, num_pixels);
        check_count("upstream credits after drain", up_credits, `VDP_OUT_DEPTH);
        $display("errors: pixel %0d, count %0d, total %0d",
                 pixel_errors, count_errors, pixel_errors + count_errors);
        if (pixel_errors + count_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(timeout_ns);
        $display("Watchdog timeout: only %0d of %0d pixels came out", received, num_pixels);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+source
+incdir+test
source/vdp_pkg.sv
source/vdp_delay_line.sv
source/vdp_alpha_lut.sv
source/vdp_blender.sv
source/vdp_credit_fifo.sv
source/vdp_compositor.sv
test/vdp_compositor_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the compositor testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    -f list.f \
    --top-module vdp_compositor_tb \
    -Mdir obj_dir

./obj_dir/Vvdp_compositor_tb > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi
